// File: colorMapper_settings.svh
// Colour mapper constants
// Screen geometry, sprite and tile sizes, memory layout and colour keys
`ifndef COLORMAPPER_SETTINGS_SVH
`define COLORMAPPER_SETTINGS_SVH

// --------------------------------------------------
// Screen and tiles
// --------------------------------------------------
`define SCREEN_W        640
`define SCREEN_H        480
`define BLOCK_SIZE      32      // Tile edge
`define PLAYER_SIZE     32      // Walking sprite edge
`define MON_SIZE        64      // Creature sprite edge

// --------------------------------------------------
// Memory layout
// --------------------------------------------------
`define MON_BASE        0       // 8 slots of 4096 words
`define PLAYER_BASE     32768   // 4 frames of 1024 words
`define TILE_BASE       36864
`define GRASS_TILE0     23
`define MEM_LATENCY     1       // Read cycles

// --------------------------------------------------
// Battle screen placement
// --------------------------------------------------
`define PLAYER_MON_X    108
`define PLAYER_MON_Y    308
`define ENEMY_MON_X     468
`define ENEMY_MON_Y     108
`define PLAYER_CIRCLE_X 140
`define PLAYER_CIRCLE_Y 340
`define ENEMY_CIRCLE_X  500
`define ENEMY_CIRCLE_Y  140
`define CIRCLE_R        50
`define FRAME_X0        80      // Half-open on the far side
`define FRAME_X1        560
`define FRAME_Y0        80
`define FRAME_Y1        400

`define TRANSPARENT     12'hFFF
`define CIRCLE_GREY     4'h6

`endif

// File: colorMapperPkg.sv
// Colour mapper types
// Coordinates, memory addresses, colours and the flags that follow a pixel
`default_nettype none

package colorMapperPkg;

    // Pixel coordinate, one word for X or Y
    typedef logic [9:0] coordT;

    // Address into the shared sprite memory
    typedef logic [17:0] memAddrT;

    // Packed colour, red in the top nibble
    typedef logic [11:0] rgb12T;

    // One colour channel
    typedef logic [3:0] chanT;

    // Per-pixel flags carried alongside the memory read
    typedef struct packed {
        logic valid;        // Pixel present
        logic battle;       // Wild battle screen
        logic spriteHit;    // Inside an active sprite box
    } pixFlagsT;

endpackage

`default_nettype wire

// File: pipeDelay.sv
// Fixed-depth delay line
// Keeps side data in step with the sprite memory read
`timescale 1ns/1ps
`default_nettype none

module pipeDelay #(
    parameter type payloadT = logic,
    parameter int  DEPTH    = 1
) (
    input  logic    clk,
    input  logic    arstN,
    input  payloadT din,
    output payloadT dout
);

    payloadT stages [DEPTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];   // Shift towards the output
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: spriteAddrGen.sv
// Sprite address stage
// Player walking frame in overworld mode, creature slots in battle mode
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module spriteAddrGen
    import colorMapperPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  coordT      drawX,
    input  coordT      drawY,
    input  coordT      playerX,
    input  coordT      playerY,
    input  logic [3:0] playerInput,
    input  logic       startWildBattle,
    input  logic [2:0] wildIndex,
    output memAddrT    spriteAddr,
    output logic       spriteHit
);

    localparam logic [10:0] PlayerSz = 11'(`PLAYER_SIZE);
    localparam logic [10:0] MonSz    = 11'(`MON_SIZE);
    localparam logic [10:0] PlMonX   = 11'(`PLAYER_MON_X);
    localparam logic [10:0] PlMonY   = 11'(`PLAYER_MON_Y);
    localparam logic [10:0] EnMonX   = 11'(`ENEMY_MON_X);
    localparam logic [10:0] EnMonY   = 11'(`ENEMY_MON_Y);
    localparam memAddrT PlayerWords  = memAddrT'(`PLAYER_SIZE * `PLAYER_SIZE);
    localparam memAddrT MonWords     = memAddrT'(`MON_SIZE * `MON_SIZE);

    logic [10:0] plDx;          // Offsets wrap to large values left/above a box
    logic [10:0] plDy;
    logic [10:0] pmDx;
    logic [10:0] pmDy;
    logic [10:0] enDx;
    logic [10:0] enDy;
    logic [1:0]  frame;
    logic        inPlayer;
    logic        inPlayerMon;
    logic        inEnemyMon;
    memAddrT     nextAddr;
    logic        nextHit;

    assign plDx = {1'b0, drawX} - {1'b0, playerX};
    assign plDy = {1'b0, drawY} - {1'b0, playerY};
    assign pmDx = {1'b0, drawX} - PlMonX;
    assign pmDy = {1'b0, drawY} - PlMonY;
    assign enDx = {1'b0, drawX} - EnMonX;
    assign enDy = {1'b0, drawY} - EnMonY;

    assign inPlayer    = (plDx < PlayerSz) && (plDy < PlayerSz);
    assign inPlayerMon = (pmDx < MonSz) && (pmDy < MonSz);
    assign inEnemyMon  = (enDx < MonSz) && (enDy < MonSz);

    // Lowest key picks the walking frame
    always_comb begin
        if (playerInput[0]) begin
            frame = 2'd0;
        end else if (playerInput[1]) begin
            frame = 2'd1;
        end else if (playerInput[2]) begin
            frame = 2'd2;
        end else if (playerInput[3]) begin
            frame = 2'd3;
        end else begin
            frame = 2'd0;                       // No key held
        end
    end

    always_comb begin
        nextAddr = '0;
        nextHit  = 1'b0;
        if (startWildBattle) begin
            if (inEnemyMon) begin               // Enemy drawn on top
                nextAddr = memAddrT'(`MON_BASE) + memAddrT'(wildIndex) * MonWords
                         + memAddrT'(enDy) * memAddrT'(`MON_SIZE) + memAddrT'(enDx);
                nextHit  = 1'b1;
            end else if (inPlayerMon) begin     // Own creature in slot 0
                nextAddr = memAddrT'(`MON_BASE)
                         + memAddrT'(pmDy) * memAddrT'(`MON_SIZE) + memAddrT'(pmDx);
                nextHit  = 1'b1;
            end
        end else if (inPlayer) begin
            nextAddr = memAddrT'(`PLAYER_BASE) + memAddrT'(frame) * PlayerWords
                     + memAddrT'(plDy) * memAddrT'(`PLAYER_SIZE) + memAddrT'(plDx);
            nextHit  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            spriteAddr <= '0;
            spriteHit  <= 1'b0;
        end else begin
            spriteAddr <= nextAddr;
            spriteHit  <= nextHit;
        end
    end

endmodule

`default_nettype wire

// File: tileAddrGen.sv
// Overworld tile address stage
// Border columns and rows, pseudo-random grass elsewhere
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module tileAddrGen
    import colorMapperPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  coordT   drawX,
    input  coordT   drawY,
    output memAddrT tileAddr
);

    localparam logic [4:0] LastCol = 5'(`SCREEN_W / `BLOCK_SIZE - 1);
    localparam logic [4:0] LastRow = 5'(`SCREEN_H / `BLOCK_SIZE - 1);
    localparam memAddrT TileWords  = memAddrT'(`BLOCK_SIZE * `BLOCK_SIZE);

    logic [4:0]  col;
    logic [4:0]  row;
    logic [11:0] grassMix;      // Hash of the tile position
    logic [4:0]  tile;
    memAddrT     nextAddr;

    assign col = 5'(drawX / `BLOCK_SIZE);
    assign row = 5'(drawY / `BLOCK_SIZE);

    assign grassMix = 12'(col ^ row) * 12'd31 + 12'(col) * 12'd17 + 12'(row) * 12'd11;

    // --------------------------------------------------
    // First matching rule picks the tile
    // --------------------------------------------------
    always_comb begin
        if (col == 5'd0) begin
            tile = 5'(row % 3);                 // Left column
        end else if (col >= LastCol) begin
            tile = 5'(row % 3) + 5'd3;          // Right column
        end else if (row == 5'd0) begin
            tile = col[0] ? 5'd5 : 5'd2;        // Top row
        end else if (row >= LastRow) begin
            tile = col[0] ? 5'd3 : 5'd0;        // Bottom row
        end else begin
            tile = 5'(`GRASS_TILE0) + 5'(grassMix % 5);
        end
    end

    assign nextAddr = memAddrT'(`TILE_BASE) + memAddrT'(tile) * TileWords
                    + memAddrT'(drawY % `BLOCK_SIZE) * memAddrT'(`BLOCK_SIZE)
                    + memAddrT'(drawX % `BLOCK_SIZE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tileAddr <= '0;
        end else begin
            tileAddr <= nextAddr;
        end
    end

endmodule

`default_nettype wire

// File: battleBackdrop.sv
// Battle screen background
// Grey platform circles over a white frame on a black surround
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module battleBackdrop
    import colorMapperPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  coordT drawX,
    input  coordT drawY,
    output rgb12T backdrop
);

    localparam logic signed [12:0] PlCx  = 13'(`PLAYER_CIRCLE_X);
    localparam logic signed [12:0] PlCy  = 13'(`PLAYER_CIRCLE_Y);
    localparam logic signed [12:0] EnCx  = 13'(`ENEMY_CIRCLE_X);
    localparam logic signed [12:0] EnCy  = 13'(`ENEMY_CIRCLE_Y);
    localparam logic signed [25:0] RadSq = 26'(`CIRCLE_R * `CIRCLE_R);

    logic signed [12:0] plDx;
    logic signed [12:0] plDy;
    logic signed [12:0] enDx;
    logic signed [12:0] enDy;
    logic signed [25:0] plDist;     // Squared distance to each centre
    logic signed [25:0] enDist;
    logic               inCircle;
    logic               inFrame;

    assign plDx = $signed({3'b000, drawX}) - PlCx;
    assign plDy = $signed({3'b000, drawY}) - PlCy;
    assign enDx = $signed({3'b000, drawX}) - EnCx;
    assign enDy = $signed({3'b000, drawY}) - EnCy;

    assign plDist = plDx * plDx + plDy * plDy;
    assign enDist = enDx * enDx + enDy * enDy;

    assign inCircle = (plDist <= RadSq) || (enDist <= RadSq);
    assign inFrame  = (drawX >= coordT'(`FRAME_X0)) && (drawX < coordT'(`FRAME_X1))
                   && (drawY >= coordT'(`FRAME_Y0)) && (drawY < coordT'(`FRAME_Y1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            backdrop <= '0;
        end else if (inCircle) begin
            backdrop <= {3{`CIRCLE_GREY}};
        end else if (inFrame) begin
            backdrop <= 12'hFFF;            // White battle frame
        end else begin
            backdrop <= 12'h000;
        end
    end

endmodule

`default_nettype wire

// File: pixelCompositor.sv
// Final colour stage
// Opaque sprite over tile or battle backdrop, registered RGB out
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module pixelCompositor
    import colorMapperPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  pixFlagsT flags,
    input  rgb12T    backdrop,
    input  rgb12T    spriteData,
    input  rgb12T    tileData,
    output logic     rgbValid,
    output chanT     red,
    output chanT     green,
    output chanT     blue
);

    logic  spriteOpaque;
    rgb12T colour;

    assign spriteOpaque = flags.spriteHit && (spriteData != `TRANSPARENT);

    // Priority mux
    always_comb begin
        if (spriteOpaque) begin
            colour = spriteData;
        end else if (flags.battle) begin
            colour = backdrop;          // Creature key shows the battle scene
        end else begin
            colour = tileData;          // Player key shows the map
        end
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rgbValid <= 1'b0;
        end else begin
            rgbValid <= flags.valid;
        end
    end

    always_ff @(posedge clk) begin
        red   <= colour[11:8];
        green <= colour[7:4];
        blue  <= colour[3:0];
    end

endmodule

`default_nettype wire

// File: colorMapperTop.sv
// Pipelined colour mapper
// Address stage, one-cycle memory read and compositing over 3 cycles
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module colorMapperTop
    import colorMapperPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       pixelValid,
    input  coordT      drawX,
    input  coordT      drawY,
    input  coordT      playerX,
    input  coordT      playerY,
    input  logic [3:0] playerInput,
    input  logic       startWildBattle,
    input  logic [2:0] wildIndex,
    output memAddrT    spriteAddr,
    output memAddrT    tileAddr,
    input  rgb12T      spriteData,
    input  rgb12T      tileData,
    output logic       rgbValid,
    output chanT       red,
    output chanT       green,
    output chanT       blue
);

    logic     validQ;
    logic     battleQ;
    logic     spriteHit;
    pixFlagsT addrFlags;        // Flags at the address stage
    pixFlagsT memFlags;         // Flags aligned with memory data
    rgb12T    backdropQ;
    rgb12T    backdropMem;

    // --------------------------------------------------
    // Stage 1 flags
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ  <= 1'b0;
            battleQ <= 1'b0;
        end else begin
            validQ  <= pixelValid;
            battleQ <= startWildBattle;
        end
    end

    assign addrFlags = '{valid: validQ, battle: battleQ, spriteHit: spriteHit};

    spriteAddrGen i_spriteAddrGen (
        .clk(clk), .arstN(arstN),
        .drawX(drawX), .drawY(drawY), .playerX(playerX), .playerY(playerY),
        .playerInput(playerInput), .startWildBattle(startWildBattle),
        .wildIndex(wildIndex), .spriteAddr(spriteAddr), .spriteHit(spriteHit)
    );

    tileAddrGen i_tileAddrGen (
        .clk(clk), .arstN(arstN), .drawX(drawX), .drawY(drawY), .tileAddr(tileAddr)
    );

    battleBackdrop i_battleBackdrop (
        .clk(clk), .arstN(arstN), .drawX(drawX), .drawY(drawY), .backdrop(backdropQ)
    );

    pipeDelay #(.payloadT(pixFlagsT), .DEPTH(`MEM_LATENCY)) flagDelay (
        .clk(clk), .arstN(arstN), .din(addrFlags), .dout(memFlags)
    );

    pipeDelay #(.payloadT(rgb12T), .DEPTH(`MEM_LATENCY)) backdropDelay (
        .clk(clk), .arstN(arstN), .din(backdropQ), .dout(backdropMem)
    );

    pixelCompositor i_pixelCompositor (
        .clk(clk), .arstN(arstN), .flags(memFlags), .backdrop(backdropMem),
        .spriteData(spriteData), .tileData(tileData),
        .rgbValid(rgbValid), .red(red), .green(green), .blue(blue)
    );

endmodule

`default_nettype wire

// File: colorMapper_assert.sv
// Colour mapper checks
// Pipeline latency, address ranges and reset state of the top level
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module colorMapperAssert
    import colorMapperPkg::*;
(
    input logic    clk,
    input logic    arstN,
    input logic    pixelValid,
    input logic    rgbValid,
    input memAddrT spriteAddr,
    input memAddrT tileAddr
);

    logic seenPixel;            // A valid pixel reached the address stage

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seenPixel <= 1'b0;
        end else if (pixelValid) begin
            seenPixel <= 1'b1;
        end
    end

    latencyCheck: assert property (@(posedge clk) disable iff (!arstN)
        rgbValid == $past(pixelValid, 3))
        else $error("rgbValid does not follow pixelValid by three cycles");

    tileRangeCheck: assert property (@(posedge clk) disable iff (!arstN)
        seenPixel |-> (tileAddr >= memAddrT'(`TILE_BASE)))
        else $error("tileAddr fell below the tile region");

    spriteRangeCheck: assert property (@(posedge clk) disable iff (!arstN)
        spriteAddr < memAddrT'(`TILE_BASE))
        else $error("spriteAddr reached into the tile region");

    resetCheck: assert property (@(posedge clk) !arstN |-> !rgbValid)
        else $error("rgbValid high while reset is held");

endmodule

`default_nettype wire

// File: tbColorMapper.sv
// Colour mapper testbench
// Memory model, directed and random pixels, reference model and output check
`timescale 1ns/1ps
`default_nettype none
`include "colorMapper_settings.svh"

module tbColorMapper
    import colorMapperPkg::*;
();

    logic       clk;
    logic       arstN;
    logic       pixelValid;
    coordT      drawX;
    coordT      drawY;
    coordT      playerX;
    coordT      playerY;
    logic [3:0] playerInput;
    logic       startWildBattle;
    logic [2:0] wildIndex;
    memAddrT    spriteAddr;
    memAddrT    tileAddr;
    rgb12T      spriteData = '0;
    rgb12T      tileData = '0;
    logic       rgbValid;
    chanT       red;
    chanT       green;
    chanT       blue;

    integer     seed;
    int         valueErrors;
    int         otherErrors;
    int         sentCount;
    int         recvCount;
    int         cycleCount;
    int         waitCycles;
    string      testName;
    rgb12T      expQ[$];
    string      nameQ[$];
    int         cycQ[$];
    int         cfgPlayerX;             // Mode values applied with the next pixel
    int         cfgPlayerY;
    int         cfgInput;
    int         cfgBattle;
    int         cfgWild;
    memAddrT    memSpriteAddr = '0;
    memAddrT    memTileAddr = '0;

    colorMapperTop i_dut (
        .clk(clk), .arstN(arstN), .pixelValid(pixelValid), .drawX(drawX), .drawY(drawY),
        .playerX(playerX), .playerY(playerY), .playerInput(playerInput),
        .startWildBattle(startWildBattle), .wildIndex(wildIndex),
        .spriteAddr(spriteAddr), .tileAddr(tileAddr),
        .spriteData(spriteData), .tileData(tileData),
        .rgbValid(rgbValid), .red(red), .green(green), .blue(blue)
    );

    bind colorMapperTop colorMapperAssert i_assert (
        .clk(clk), .arstN(arstN), .pixelValid(pixelValid), .rgbValid(rgbValid),
        .spriteAddr(spriteAddr), .tileAddr(tileAddr)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycleCount++;

    // --------------------------------------------------
    // Memory model with a one-cycle read on both ports
    // --------------------------------------------------
    function automatic rgb12T memWord(input memAddrT addr);
        if (addr[5:0] == 6'h3F) begin
            return `TRANSPARENT;        // Last word of every 64
        end
        return addr[11:0] ^ addr[17:6];
    endfunction

    always @(negedge clk) begin
        memSpriteAddr = spriteAddr;     // Stable mid-cycle
        memTileAddr   = tileAddr;
    end

    always @(posedge clk) begin
        #0.5;
        spriteData = memWord(memSpriteAddr);
        tileData   = memWord(memTileAddr);
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic bit inCircle(input int x, input int y, input int cx, input int cy);
        return (x - cx) * (x - cx) + (y - cy) * (y - cy) <= `CIRCLE_R * `CIRCLE_R;
    endfunction

    function automatic rgb12T refPixel(input int x, input int y, input int px, input int py,
                                       input int keys, input int battle, input int slot);
        int    col;
        int    row;
        int    tile;
        int    frame;
        int    addr;
        bit    hit;
        rgb12T word;
        col   = x / `BLOCK_SIZE;
        row   = y / `BLOCK_SIZE;
        hit   = 1'b0;
        addr  = 0;
        frame = 0;
        if (battle != 0) begin
            if (x >= `ENEMY_MON_X && x < `ENEMY_MON_X + `MON_SIZE
                && y >= `ENEMY_MON_Y && y < `ENEMY_MON_Y + `MON_SIZE) begin
                hit  = 1'b1;
                addr = slot * 4096 + (y - `ENEMY_MON_Y) * 64 + (x - `ENEMY_MON_X);
            end else if (x >= `PLAYER_MON_X && x < `PLAYER_MON_X + `MON_SIZE
                && y >= `PLAYER_MON_Y && y < `PLAYER_MON_Y + `MON_SIZE) begin
                hit  = 1'b1;
                addr = (y - `PLAYER_MON_Y) * 64 + (x - `PLAYER_MON_X);
            end
        end else if (x >= px && x < px + 32 && y >= py && y < py + 32) begin
            hit = 1'b1;
            if (keys[0]) frame = 0;
            else if (keys[1]) frame = 1;
            else if (keys[2]) frame = 2;
            else if (keys[3]) frame = 3;
            addr = `PLAYER_BASE + frame * 1024 + (y - py) * 32 + (x - px);
        end
        word = memWord(memAddrT'(addr));
        if (hit && word != `TRANSPARENT) return word;
        if (battle != 0) begin
            if (inCircle(x, y, `PLAYER_CIRCLE_X, `PLAYER_CIRCLE_Y)
                || inCircle(x, y, `ENEMY_CIRCLE_X, `ENEMY_CIRCLE_Y)) return 12'h666;
            if (x >= `FRAME_X0 && x < `FRAME_X1 && y >= `FRAME_Y0 && y < `FRAME_Y1)
                return 12'hFFF;
            return 12'h000;
        end
        if (col == 0) tile = row % 3;
        else if (col >= 19) tile = row % 3 + 3;
        else if (row == 0) tile = (col % 2 == 1) ? 5 : 2;
        else if (row >= 14) tile = (col % 2 == 1) ? 3 : 0;
        else tile = `GRASS_TILE0 + (((col ^ row) * 31 + col * 17 + row * 11) % 5);
        return memWord(memAddrT'(`TILE_BASE + tile * 1024 + (y % 32) * 32 + (x % 32)));
    endfunction

    function automatic int randRange(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // One pixel per call with its mode values
    task automatic drivePixel(input int x, input int y, input logic valid);
        @(posedge clk);
        #0.5;
        pixelValid      = valid;
        drawX           = coordT'(x);
        drawY           = coordT'(y);
        playerX         = coordT'(cfgPlayerX);
        playerY         = coordT'(cfgPlayerY);
        playerInput     = 4'(cfgInput);
        startWildBattle = 1'(cfgBattle);
        wildIndex       = 3'(cfgWild);
        if (valid) begin
            expQ.push_back(refPixel(x, y, cfgPlayerX, cfgPlayerY, cfgInput, cfgBattle, cfgWild));
            nameQ.push_back(testName);
            cycQ.push_back(cycleCount);
            sentCount++;
        end
    endtask

    // --------------------------------------------------
    // Output comparer
    // --------------------------------------------------
    always @(negedge clk) begin
        rgb12T got;
        rgb12T exp;
        string name;
        int    cyc;
        if (arstN && rgbValid) begin
            got = {red, green, blue};
            recvCount++;
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("rgbValid rose with no pixel outstanding at %0t", $time);
            end else begin
                exp  = expQ.pop_front();
                name = nameQ.pop_front();
                cyc  = cycQ.pop_front();
                assert (got == exp) else begin
                    valueErrors++;
                    $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
                end
                assert (cycleCount - cyc == 3) else begin
                    valueErrors++;
                    $display("[FAIL] %s latency: expected 3, actual %0d",
                             name, cycleCount - cyc);
                end
            end
        end
    end

    initial begin
        seed = 96874;
        {valueErrors, otherErrors, sentCount, recvCount, cycleCount} = '0;
        arstN = 1'b0;
        pixelValid = 1'b0;
        drawX = '0;
        drawY = '0;
        playerX = '0;
        playerY = '0;
        playerInput = '0;
        startWildBattle = 1'b0;
        wildIndex = '0;
        cfgPlayerX = 300;
        cfgPlayerY = 200;
        cfgInput = 1;
        cfgBattle = 0;
        cfgWild = 0;
        testName = "reset";
        repeat (8) begin
            @(posedge clk);
            assert (rgbValid == 1'b0) else begin
                valueErrors++;
                $display("[FAIL] %s rgbValid: expected 0, actual %b", testName, rgbValid);
            end
            assert (spriteAddr == '0) else begin
                valueErrors++;
                $display("[FAIL] %s spriteAddr: expected 0, actual %h", testName, spriteAddr);
            end
            assert (tileAddr == '0) else begin
                valueErrors++;
                $display("[FAIL] %s tileAddr: expected 0, actual %h", testName, tileAddr);
            end
        end
        #0.5;
        arstN = 1'b1;
        repeat (4) drivePixel(0, 0, 1'b0);

        testName = "tiles";             // Border columns and rows, then grass
        for (int r = 0; r < 15; r++) begin
            drivePixel(3, r * 32 + 5, 1'b1);
            drivePixel(630, r * 32 + 9, 1'b1);
        end
        for (int c = 0; c < 20; c++) begin
            drivePixel(c * 32 + 4, 2, 1'b1);
            drivePixel(c * 32 + 17, 470, 1'b1);
        end
        repeat (150) drivePixel(randRange(0, 639), randRange(0, 479), 1'b1);

        testName = "player";            // Every key combination
        for (int k = 0; k < 16; k++) begin
            cfgInput   = k;
            cfgPlayerX = randRange(0, 600);
            cfgPlayerY = randRange(0, 440);
            drivePixel(cfgPlayerX + 31, cfgPlayerY + 1, 1'b1);     // Transparent word
            repeat (20) begin
                drivePixel(cfgPlayerX + randRange(0, 31), cfgPlayerY + randRange(0, 31), 1'b1);
            end
        end

        testName = "creatures";
        cfgBattle = 1;
        for (int w = 0; w < 8; w++) begin
            cfgWild = w;
            drivePixel(`ENEMY_MON_X + 63, `ENEMY_MON_Y + w, 1'b1);
            drivePixel(`PLAYER_MON_X + 63, `PLAYER_MON_Y + w, 1'b1);
            repeat (15) begin
                drivePixel(`ENEMY_MON_X + randRange(0, 63),
                           `ENEMY_MON_Y + randRange(0, 63), 1'b1);
                drivePixel(`PLAYER_MON_X + randRange(0, 63),
                           `PLAYER_MON_Y + randRange(0, 63), 1'b1);
            end
        end

        testName = "backdrop";          // Circle rims and frame corners
        drivePixel(140, 390, 1'b1);
        drivePixel(140, 391, 1'b1);
        drivePixel(90, 340, 1'b1);
        drivePixel(89, 340, 1'b1);
        drivePixel(550, 140, 1'b1);
        drivePixel(500, 190, 1'b1);
        drivePixel(79, 79, 1'b1);
        drivePixel(80, 80, 1'b1);
        drivePixel(559, 399, 1'b1);
        drivePixel(560, 400, 1'b1);
        drivePixel(639, 479, 1'b1);
        repeat (150) drivePixel(randRange(0, 639), randRange(0, 479), 1'b1);

        testName = "stream";            // Gaps and mode changes between pixels
        repeat (200) begin
            cfgBattle = randRange(0, 1);
            cfgWild   = randRange(0, 7);
            cfgInput  = randRange(0, 15);
            drivePixel(randRange(0, 639), randRange(0, 479), 1'(randRange(0, 3) != 0));
        end
        drivePixel(0, 0, 1'b0);

        waitCycles = 0;
        while (recvCount < sentCount && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if (recvCount < sentCount) begin
            otherErrors++;
            $display("Timed out with %0d pixels still outstanding", sentCount - recvCount);
        end
        repeat (5) @(posedge clk);
        assert (recvCount == sentCount) else begin
            otherErrors++;
            $display("Sent %0d pixels but counted %0d rgbValid pulses", sentCount, recvCount);
        end
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
colorMapperPkg.sv
pipeDelay.sv
spriteAddrGen.sv
tileAddrGen.sv
battleBackdrop.sv
pixelCompositor.sv
colorMapperTop.sv
colorMapper_assert.sv
tbColorMapper.sv

// File: Makefile
# Verilator build and run for the colour mapper testbench

TOP       ?= tbColorMapper
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
